/* all.f */
+incdir+include
design/pkt_chk_pkg.sv
design/pkt_apb_regs.sv
design/pkt_rx_framer.sv
design/pkt_fifo.sv
design/pkt_checker.sv
design/pkt_chk_top.sv
tests/tb_pkt_chk.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_pkt_chk -f all.f
	./obj_dir/Vtb_pkt_chk | tee /dev/stderr | grep "Test OK" > /dev/null

clean:
	rm -rf obj_dir

/* tests/tb_pkt_chk.sv */
// Self-checking testbench; idle gaps, lengths and seeds come from a fixed-seed LCG
// Expected STATUS and SLOT words are built here from the register map
`include "pkt_chk_cfg.svh"

module tb_pkt_chk;

    localparam int AW    = `PKT_APB_ADDR_W;
    localparam int NS    = `PKT_NUM_SLOTS;
    localparam int LIMIT = 200;
    localparam logic [AW-1:0] STATUS_ADDR = AW'('h00);
    localparam logic [AW-1:0] CLEAR_ADDR  = AW'('h04);
    localparam logic [AW-1:0] SLOT_BASE   = AW'('h10);

    logic                          axis_packet_in_monitor;
    logic                          arst_n;
    logic                          psel, penable, pwrite, pready, pslverr;
    logic [AW-1:0]                 paddr;
    logic [31:0]                   pwdata, prdata;
    logic                          in_valid, in_ready, in_last;
    logic [`PKT_DATA_BYTES*8-1:0]  in_data;
    logic [`PKT_DATA_BYTES-1:0]    in_keep;
    logic [31:0]                   lcg_state;
    int                            exp_pass, exp_fail;
    logic [NS-1:0]                 exp_map;
    logic [31:0]                   exp_slot [NS];

    pkt_chk_top i_pkt_chk_top (.*);

    initial begin
        axis_packet_in_monitor = 1'b0;
        forever #4 axis_packet_in_monitor = ~axis_packet_in_monitor;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        a_value: assert (got == exp)
            else fail_now($sformatf("** Error at %0t: %s is 0x%0h, expected 0x%0h",
                                    $time, what, got, exp));
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Two-phase APB transfer sampled mid-cycle in the access phase
    task automatic apb_access(input logic wr, input logic [AW-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int tries;
        tries = 0;
        @(posedge axis_packet_in_monitor);
        #1;
        psel   = 1'b1;
        pwrite = wr;
        paddr  = addr;
        pwdata = wdata;
        @(posedge axis_packet_in_monitor);
        #1;
        penable = 1'b1;
        #2;
        while (!pready) begin
            tries++;
            if (tries > LIMIT) fail_now("Timeout waiting for pready");
            @(posedge axis_packet_in_monitor);
            #3;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge axis_packet_in_monitor);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Poll STATUS until every sent packet has a verdict, then compare all fields
    task automatic wait_results();
        logic [31:0] st;
        logic [31:0] exp_st;
        logic        err;
        int          tries;
        tries            = 0;
        exp_st           = '0;
        exp_st[NS-1:0]   = exp_map;
        exp_st[15:8]     = 8'(exp_pass);
        exp_st[23:16]    = 8'(exp_fail);
        apb_access(1'b0, STATUS_ADDR, '0, st, err);
        while (int'(st[15:8]) + int'(st[23:16]) != exp_pass + exp_fail) begin
            tries++;
            if (tries > LIMIT) fail_now("Timeout waiting for packet results");
            apb_access(1'b0, STATUS_ADDR, '0, st, err);
        end
        expect_eq(st, exp_st, "STATUS");
        expect_eq(32'(err), 32'd0, "STATUS read pslverr");
    endtask

    task automatic check_slots();
        logic [31:0] rd;
        logic        err;
        for (int n = 0; n < NS; n++) begin
            apb_access(1'b0, SLOT_BASE + AW'(4 * n), '0, rd, err);
            expect_eq(rd, exp_slot[n], "SLOT readback");
        end
    endtask

    task automatic arm_slot(input int n, input logic [6:0] len, input logic [7:0] seed);
        logic [31:0] rd;
        logic        err;
        exp_slot[n] = {16'h0, 1'b1, len, seed};
        apb_access(1'b1, SLOT_BASE + AW'(4 * n), exp_slot[n], rd, err);
        expect_eq(32'(err), 32'd0, "SLOT write pslverr");
        check_slots();
    endtask

    task automatic clear_counters();
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, CLEAR_ADDR, '0, rd, err);
        expect_eq(32'(err), 32'd0, "CLEAR write pslverr");
        exp_pass = 0;
        exp_fail = 0;
        exp_map  = '0;
        wait_results();
    endtask

    // Byte 0 names the slot, byte b is seed + b, bad_pos gets inverted
    task automatic send_packet(input logic [7:0] id, input logic [7:0] seed, input int len,
                               input int bad_pos, input logic gaps);
        int         nwords;
        int         pos;
        int         tries;
        logic [7:0] val;
        nwords = (len + `PKT_DATA_BYTES - 1) / `PKT_DATA_BYTES;
        for (int w = 0; w < nwords; w++) begin
            if (gaps) begin
                in_valid = 1'b0;
                repeat ((lcg_next() >> 16) % 3) begin
                    @(posedge axis_packet_in_monitor);
                    #1;
                end
            end
            for (int b = 0; b < `PKT_DATA_BYTES; b++) begin
                pos        = w * `PKT_DATA_BYTES + b;
                in_keep[b] = (pos < len);
                val        = (pos == 0) ? id : seed + 8'(pos);
                if (pos == bad_pos) val = ~val;
                // Junk past the end of the packet
                if (pos >= len) val = 8'(lcg_next() >> 24);
                in_data[b*8 +: 8] = val;
            end
            in_last  = (w == nwords - 1);
            in_valid = 1'b1;
            tries    = 0;
            while (!in_ready) begin
                tries++;
                if (tries > LIMIT) fail_now("Timeout waiting for in_ready");
                @(posedge axis_packet_in_monitor);
                #1;
            end
            @(posedge axis_packet_in_monitor);
            #1;
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    ////////////////////////////////////////
    // Stream checks
    ////////////////////////////////////////

    a_trailer_gap: assert property (
        @(posedge axis_packet_in_monitor) disable iff (!arst_n)
        in_valid && in_ready && in_last |=> !in_ready
    ) else fail_now($sformatf("** Error at %0t: in_ready high after a last word", $time));

    a_full_stalls: assert property (
        @(posedge axis_packet_in_monitor) disable iff (!arst_n)
        i_pkt_chk_top.full |-> !in_ready
    ) else fail_now($sformatf("** Error at %0t: in_ready high with the FIFO full", $time));

    // Trailer may slip behind a full FIFO by one cycle
    a_ready_cause: assert property (
        @(posedge axis_packet_in_monitor) disable iff (!arst_n)
        !in_ready |-> i_pkt_chk_top.full || $past(i_pkt_chk_top.full)
                      || $past(in_valid && in_ready && in_last)
    ) else fail_now($sformatf("** Error at %0t: in_ready low without cause", $time));

    a_no_wait: assert property (
        @(posedge axis_packet_in_monitor) disable iff (!arst_n) pready
    ) else fail_now($sformatf("** Error at %0t: pready low", $time));

    initial begin
        logic [31:0] rd;
        logic        err;
        int          lens [NS];
        logic [7:0]  seeds [NS];
        arst_n    = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        in_valid  = 1'b0;
        in_data   = '0;
        in_keep   = '0;
        in_last   = 1'b0;
        lcg_state = 32'h42b8_0a39;
        exp_pass  = 0;
        exp_fail  = 0;
        exp_map   = '0;
        for (int n = 0; n < NS; n++) exp_slot[n] = '0;
        repeat (4) @(posedge axis_packet_in_monitor);
        #1;
        arst_n = 1'b1;

        // Reset state
        expect_eq(32'(in_ready), 32'd1, "in_ready after reset");
        wait_results();
        check_slots();

        // Good packet with a partial last word
        arm_slot(1, 7'd23, 8'h30);
        send_packet(8'd1, 8'h30, 23, -1, 1'b1);
        exp_pass++;
        exp_map[1] = 1'b1;
        wait_results();

        // Failing packets leave pass count and bitmap alone
        arm_slot(2, 7'd17, 8'ha5);
        send_packet(8'd2, 8'ha5, 17, 9, 1'b1);
        exp_fail++;
        wait_results();
        send_packet(8'd2, 8'ha5, 13, -1, 1'b1);
        exp_fail++;
        wait_results();
        // Slot 3 holds a matching length and seed but stays unarmed
        exp_slot[3] = {16'h0, 1'b0, 7'd12, 8'h5c};
        apb_access(1'b1, SLOT_BASE + AW'(4 * 3), exp_slot[3], rd, err);
        expect_eq(32'(err), 32'd0, "SLOT write pslverr");
        check_slots();
        send_packet(8'd3, 8'h5c, 12, -1, 1'b1);
        exp_fail++;
        wait_results();
        // Oversize with a matching slot length
        arm_slot(0, 7'(`PKT_MAX_BYTES + 2), 8'h11);
        send_packet(8'd0, 8'h11, `PKT_MAX_BYTES + 2, -1, 1'b1);
        exp_fail++;
        wait_results();
        send_packet(8'd1, 8'h30, 23, -1, 1'b1);
        exp_fail++;
        wait_results();
        // Slot 2 was never marked by its failures
        send_packet(8'd2, 8'ha5, 17, -1, 1'b1);
        exp_pass++;
        exp_map[2] = 1'b1;
        wait_results();

        // Error responses change nothing
        apb_access(1'b0, AW'('h08), '0, rd, err);
        expect_eq(32'(err), 32'd1, "pslverr on unmapped read");
        apb_access(1'b1, SLOT_BASE + AW'(4 * NS), 32'h0000_ffff, rd, err);
        expect_eq(32'(err), 32'd1, "pslverr on unmapped write");
        apb_access(1'b1, STATUS_ADDR, 32'hffff_ffff, rd, err);
        expect_eq(32'(err), 32'd1, "pslverr on STATUS write");
        wait_results();
        check_slots();

        // CLEAR zeroes counters and bitmap but keeps the table
        clear_counters();
        check_slots();

        // Back-to-back packets in every slot
        for (int r = 0; r < 2; r++) begin
            if (r > 0) clear_counters();
            for (int n = 0; n < NS; n++) begin
                lens[n]  = 1 + int'((lcg_next() >> 16) % `PKT_MAX_BYTES);
                seeds[n] = 8'(lcg_next() >> 24);
                arm_slot(n, 7'(lens[n]), seeds[n]);
            end
            for (int n = 0; n < NS; n++) begin
                send_packet(8'(n), seeds[n], lens[n], -1, 1'b0);
            end
            exp_pass += NS;
            exp_map   = '1;
            wait_results();
        end

        $display("Test OK");
        $finish;
    end

endmodule

/* design/pkt_chk_top.sv */
// Packet checker top: framer, FIFO, checker and APB registers
// Stream and APB share one clock and one asynchronous reset
`include "pkt_chk_cfg.svh"

module pkt_chk_top (
    input  logic                            axis_packet_in_monitor,
    input  logic                            arst_n,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [`PKT_APB_ADDR_W-1:0]      paddr,
    input  logic [31:0]                     pwdata,
    output logic [31:0]                     prdata,
    output logic                            pready,
    output logic                            pslverr,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  logic [`PKT_DATA_BYTES*8-1:0]    in_data,
    input  logic [`PKT_DATA_BYTES-1:0]      in_keep,
    input  logic                            in_last
);

    logic                                   wr_en;
    pkt_chk_pkg::pkt_entry_t                wr_entry;
    logic                                   wr_is_trailer;
    logic                                   full;
    logic                                   rd_en;
    pkt_chk_pkg::pkt_entry_t                rd_entry;
    logic                                   rd_is_trailer;
    logic                                   empty;
    logic [`PKT_NUM_SLOTS-1:0]              slot_armed;
    logic [`PKT_NUM_SLOTS-1:0][6:0]         slot_len;
    logic [`PKT_NUM_SLOTS-1:0][7:0]         slot_seed;
    logic                                   clear;
    logic                                   result_valid;
    logic                                   result_pass;
    logic [$clog2(`PKT_NUM_SLOTS)-1:0]      result_slot;

    pkt_rx_framer i_pkt_rx_framer (
        .axis_packet_in_monitor, .arst_n,
        .in_valid, .in_data, .in_keep, .in_last, .full,
        .in_ready, .wr_en, .wr_entry, .wr_is_trailer
    );

    pkt_fifo i_pkt_fifo (
        .axis_packet_in_monitor, .arst_n,
        .wr_en, .wr_entry, .wr_is_trailer, .rd_en,
        .rd_entry, .rd_is_trailer, .full, .empty
    );

    pkt_checker i_pkt_checker (
        .axis_packet_in_monitor, .arst_n,
        .rd_entry, .rd_is_trailer, .empty,
        .slot_armed, .slot_len, .slot_seed, .clear,
        .rd_en, .result_valid, .result_pass, .result_slot
    );

    pkt_apb_regs i_pkt_apb_regs (
        .axis_packet_in_monitor, .arst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .result_valid, .result_pass, .result_slot,
        .prdata, .pready, .pslverr,
        .slot_armed, .slot_len, .slot_seed, .clear
    );

endmodule

/* design/pkt_checker.sv */
// Pops one entry per cycle; byte 0 selects the slot, byte b must be seed + b
// Slot ids at or above PKT_NUM_SLOTS always fail
`include "pkt_chk_cfg.svh"

module pkt_checker (
    input  logic                                 axis_packet_in_monitor,
    input  logic                                 arst_n,
    input  pkt_chk_pkg::pkt_entry_t              rd_entry,
    input  logic                                 rd_is_trailer,
    input  logic                                 empty,
    input  logic [`PKT_NUM_SLOTS-1:0]            slot_armed,
    input  logic [`PKT_NUM_SLOTS-1:0][6:0]       slot_len,
    input  logic [`PKT_NUM_SLOTS-1:0][7:0]       slot_seed,
    input  logic                                 clear,
    output logic                                 rd_en,
    output logic                                 result_valid,
    output logic                                 result_pass,
    output logic [$clog2(`PKT_NUM_SLOTS)-1:0]    result_slot
);

    localparam int SLOT_W = $clog2(`PKT_NUM_SLOTS);

    logic [7:0]                 byte_pos;
    logic [7:0]                 slot_id_q;
    logic [7:0]                 cur_id;
    logic [7:0]                 cur_seed;
    logic                       mm_q;
    logic [7:0]                 mm_pos_q;
    logic                       word_mm;
    logic [7:0]                 word_mm_pos;
    logic [`PKT_NUM_SLOTS-1:0]  rcvd;
    logic [SLOT_W-1:0]          slot;
    logic                       mm_in_len;
    logic                       pass;
    pkt_chk_pkg::pkt_trailer_t  trl;

    assign rd_en = !empty;

    // Slot id comes from byte 0, so the first word looks it up directly
    assign cur_id   = (byte_pos == '0) ? rd_entry.data[0] : slot_id_q;
    assign cur_seed = slot_seed[cur_id[SLOT_W-1:0]];

    ////////////////////////////////////////
    // Byte compare, first mismatch only
    ////////////////////////////////////////

    always_comb begin
        logic [7:0] pos;
        word_mm     = 1'b0;
        word_mm_pos = '0;
        for (int i = `PKT_DATA_BYTES - 1; i >= 0; i--) begin
            pos = byte_pos + 8'(i);
            if (pos != '0 && rd_entry.data[i] != cur_seed + pos) begin
                word_mm     = 1'b1;
                word_mm_pos = pos;
            end
        end
    end

    ////////////////////////////////////////
    // Verdict on the trailer
    ////////////////////////////////////////

    assign trl       = rd_entry.trailer;
    assign slot      = slot_id_q[SLOT_W-1:0];
    // Mismatches past the packet length are padding
    assign mm_in_len = mm_q && (mm_pos_q < {1'b0, trl.len});
    assign pass      = (slot_id_q < 8'(`PKT_NUM_SLOTS)) && slot_armed[slot] && !rcvd[slot]
                       && (trl.len == slot_len[slot]) && !trl.oversize && !mm_in_len;

    always_ff @(posedge axis_packet_in_monitor or negedge arst_n) begin
        if (!arst_n) begin
            byte_pos     <= '0;
            mm_q         <= 1'b0;
            rcvd         <= '0;
            result_valid <= 1'b0;
            result_pass  <= 1'b0;
            result_slot  <= '0;
        end else begin
            result_valid <= 1'b0;
            if (clear) rcvd <= '0;
            if (rd_en) begin
                if (rd_is_trailer) begin
                    byte_pos     <= '0;
                    mm_q         <= 1'b0;
                    result_valid <= 1'b1;
                    result_pass  <= pass;
                    result_slot  <= slot;
                    if (pass) rcvd[slot] <= 1'b1;
                end else begin
                    byte_pos <= byte_pos + 8'(`PKT_DATA_BYTES);
                    if (word_mm) mm_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge axis_packet_in_monitor) begin
        if (rd_en && !rd_is_trailer) begin
            if (byte_pos == '0) slot_id_q <= rd_entry.data[0];
            if (word_mm && !mm_q) mm_pos_q <= word_mm_pos;
        end
    end

endmodule

/* design/pkt_fifo.sv */
// Show-ahead FIFO; the head entry is valid whenever empty is low
// Depth must be a power of two so the pointers wrap on their own
`include "pkt_chk_cfg.svh"

module pkt_fifo (
    input  logic                     axis_packet_in_monitor,
    input  logic                     arst_n,
    input  logic                     wr_en,
    input  pkt_chk_pkg::pkt_entry_t  wr_entry,
    input  logic                     wr_is_trailer,
    input  logic                     rd_en,
    output pkt_chk_pkg::pkt_entry_t  rd_entry,
    output logic                     rd_is_trailer,
    output logic                     full,
    output logic                     empty
);

    localparam int PTR_W = $clog2(`PKT_FIFO_DEPTH);

    pkt_chk_pkg::pkt_entry_t     mem [`PKT_FIFO_DEPTH];
    logic [`PKT_FIFO_DEPTH-1:0]  trl_mem;
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [PTR_W:0]              count;

    assign full          = (count == (PTR_W+1)'(`PKT_FIFO_DEPTH));
    assign empty         = (count == '0);
    assign rd_entry      = mem[rd_ptr];
    assign rd_is_trailer = trl_mem[rd_ptr];

    // Storage
    always_ff @(posedge axis_packet_in_monitor) begin
        if (wr_en) begin
            mem[wr_ptr]     <= wr_entry;
            trl_mem[wr_ptr] <= wr_is_trailer;
        end
    end

    always_ff @(posedge axis_packet_in_monitor or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (
        @(posedge axis_packet_in_monitor) disable iff (!arst_n)
        wr_en |-> !full
    );

    a_no_underflow: assert property (
        @(posedge axis_packet_in_monitor) disable iff (!arst_n)
        rd_en |-> !empty
    );

endmodule

/* design/pkt_rx_framer.sv */
// Stream ingress; keep must be contiguous from bit 0 and only the last word partial
// One dead cycle after each last word while the trailer is written
`include "pkt_chk_cfg.svh"

module pkt_rx_framer (
    input  logic                              axis_packet_in_monitor,
    input  logic                              arst_n,
    input  logic                              in_valid,
    input  logic [`PKT_DATA_BYTES*8-1:0]      in_data,
    input  logic [`PKT_DATA_BYTES-1:0]        in_keep,
    input  logic                              in_last,
    input  logic                              full,
    output logic                              in_ready,
    output logic                              wr_en,
    output pkt_chk_pkg::pkt_entry_t           wr_entry,
    output logic                              wr_is_trailer
);

    logic                       accept;
    logic                       trl_pend;
    logic                       over_q;
    logic                       over_now;
    logic [7:0]                 byte_cnt;
    logic [7:0]                 next_cnt;
    pkt_chk_pkg::pkt_trailer_t  trl_q;

    assign in_ready = !full && !trl_pend;
    assign accept   = in_valid && in_ready;

    // Full words add DATA_BYTES, the last word adds its keep popcount
    assign next_cnt = byte_cnt + (in_last ? 8'($countones(in_keep)) : 8'(`PKT_DATA_BYTES));
    assign over_now = over_q || (next_cnt > 8'(`PKT_MAX_BYTES));

    always_ff @(posedge axis_packet_in_monitor or negedge arst_n) begin
        if (!arst_n) begin
            trl_pend <= 1'b0;
            over_q   <= 1'b0;
            byte_cnt <= '0;
        end else begin
            if (trl_pend && !full) trl_pend <= 1'b0;
            if (accept) begin
                if (in_last) begin
                    trl_pend <= 1'b1;
                    over_q   <= 1'b0;
                    byte_cnt <= '0;
                end else begin
                    over_q <= over_now;
                    // Hold the count once oversize so it cannot wrap
                    if (!over_now) byte_cnt <= next_cnt;
                end
            end
        end
    end

    always_ff @(posedge axis_packet_in_monitor) begin
        if (accept && in_last) begin
            trl_q.pad      <= '0;
            trl_q.oversize <= over_now;
            trl_q.len      <= next_cnt[6:0];
        end
    end

    ////////////////////////////////////////
    // FIFO write side
    ////////////////////////////////////////

    always_comb begin
        wr_is_trailer = trl_pend;
        if (trl_pend) begin
            wr_en            = !full;
            wr_entry.trailer = trl_q;
        end else begin
            wr_en         = accept;
            wr_entry.data = in_data;
        end
    end

    a_keep_contiguous: assert property (
        @(posedge axis_packet_in_monitor) disable iff (!arst_n)
        accept |-> (in_keep != '0) && ((in_keep & (in_keep + 1'b1)) == 0)
                   && (in_last || (&in_keep))
    );

endmodule

/* design/pkt_apb_regs.sv */
// APB register block with no wait states; pslverr on unmapped addresses and STATUS writes
// Counters saturate at 255 and are zeroed only by a CLEAR write
`include "pkt_chk_cfg.svh"

module pkt_apb_regs (
    input  logic                                     axis_packet_in_monitor,
    input  logic                                     arst_n,
    input  logic                                     psel,
    input  logic                                     penable,
    input  logic                                     pwrite,
    input  logic [`PKT_APB_ADDR_W-1:0]               paddr,
    input  logic [31:0]                              pwdata,
    input  logic                                     result_valid,
    input  logic                                     result_pass,
    input  logic [$clog2(`PKT_NUM_SLOTS)-1:0]        result_slot,
    output logic [31:0]                              prdata,
    output logic                                     pready,
    output logic                                     pslverr,
    output logic [`PKT_NUM_SLOTS-1:0]                slot_armed,
    output logic [`PKT_NUM_SLOTS-1:0][6:0]           slot_len,
    output logic [`PKT_NUM_SLOTS-1:0][7:0]           slot_seed,
    output logic                                     clear
);

    localparam int SLOT_W = $clog2(`PKT_NUM_SLOTS);
    localparam int AW     = `PKT_APB_ADDR_W;

    logic              access;
    logic              wr;
    logic              hit_status;
    logic              hit_clear;
    logic              hit_slot;
    logic [AW-1:0]     slot_off;
    logic [SLOT_W-1:0] slot_idx;
    logic [7:0]        pass_cnt;
    logic [7:0]        fail_cnt;
    logic [`PKT_NUM_SLOTS-1:0] rcvd_map;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    assign access     = psel && penable;
    assign wr         = access && pwrite;
    assign hit_status = (paddr == AW'('h00));
    assign hit_clear  = (paddr == AW'('h04));
    assign slot_off   = paddr - AW'('h10);
    assign slot_idx   = slot_off[SLOT_W+1:2];
    assign hit_slot   = (paddr >= AW'('h10)) && (slot_off[1:0] == 2'b00)
                        && ((slot_off >> 2) < `PKT_NUM_SLOTS);

    assign pready  = 1'b1;
    assign pslverr = access && (!(hit_status || hit_clear || hit_slot) || (pwrite && hit_status));

    always_comb begin
        prdata = '0;
        if (hit_status) begin
            prdata[`PKT_NUM_SLOTS-1:0] = rcvd_map;
            prdata[15:8]               = pass_cnt;
            prdata[23:16]              = fail_cnt;
        end else if (hit_slot) begin
            prdata[15:0] = {slot_armed[slot_idx], slot_len[slot_idx], slot_seed[slot_idx]};
        end
    end

    ////////////////////////////////////////
    // Slot table, clear pulse, counters
    ////////////////////////////////////////

    always_ff @(posedge axis_packet_in_monitor or negedge arst_n) begin
        if (!arst_n) begin
            slot_armed <= '0;
            slot_len   <= '0;
            slot_seed  <= '0;
            clear      <= 1'b0;
            pass_cnt   <= '0;
            fail_cnt   <= '0;
            rcvd_map   <= '0;
        end else begin
            clear <= wr && hit_clear;
            if (wr && hit_slot) begin
                slot_seed[slot_idx]  <= pwdata[7:0];
                slot_len[slot_idx]   <= pwdata[14:8];
                slot_armed[slot_idx] <= pwdata[15];
            end
            // Clear wins over a result landing in the same cycle
            if (clear) begin
                pass_cnt <= '0;
                fail_cnt <= '0;
                rcvd_map <= '0;
            end else if (result_valid) begin
                if (result_pass) begin
                    rcvd_map[result_slot] <= 1'b1;
                    if (pass_cnt != 8'hff) pass_cnt <= pass_cnt + 8'd1;
                end else if (fail_cnt != 8'hff) begin
                    fail_cnt <= fail_cnt + 8'd1;
                end
            end
        end
    end

    // An error response leaves the slot table and the clear pulse untouched
    a_slverr_no_effect: assert property (
        @(posedge axis_packet_in_monitor) disable iff (!arst_n)
        pslverr |=> $stable(slot_armed) && $stable(slot_len) && $stable(slot_seed)
                    && !clear
    );

endmodule

/* design/pkt_chk_pkg.sv */
// Buffer entry types for the packet checker
// One entry is one stream word, read either as data bytes or as a trailer
`include "pkt_chk_cfg.svh"

package pkt_chk_pkg;

    // Trailer written by the framer after the last data word
    typedef struct packed {
        logic [`PKT_DATA_BYTES*8-9:0] pad;
        logic                         oversize;
        logic [6:0]                   len;
    } pkt_trailer_t;

    // Which view applies is carried by the is_trailer bit beside the entry
    typedef union packed {
        logic [`PKT_DATA_BYTES-1:0][7:0] data;
        pkt_trailer_t                    trailer;
    } pkt_entry_t;

endpackage

/* include/pkt_chk_cfg.svh */
// Sizes shared by the RTL and the testbench
// PKT_FIFO_DEPTH must be a power of two; PKT_MAX_BYTES must fit in 7 bits
`ifndef PKT_CHK_CFG_SVH
`define PKT_CHK_CFG_SVH

// Bytes per stream word
`define PKT_DATA_BYTES 4

// Longest legal packet in bytes
`define PKT_MAX_BYTES 64

// Buffer entries between framer and checker
`define PKT_FIFO_DEPTH 16

// Expectation slots, one per packet id
`define PKT_NUM_SLOTS 4

// APB address width
`define PKT_APB_ADDR_W 8

`endif
